// ==== mc_wh_pkg.sv ====
// Shared widths and types for the manycore to wormhole bridge.
// Modules refer to these through scoped names.

package mc_wh_pkg;

  // Flit and header geometry
  localparam int flit_width   = 16;
  localparam int coord_width  = 4;
  localparam int len_width    = 2;
  localparam int header_width = 10;

  // Flits per packet on each net
  localparam int req_flits  = 3;
  localparam int resp_flits = 2;

  // Manycore payload widths
  localparam int req_payload_width  = 38;
  localparam int resp_payload_width = 22;

  // Widest wormhole packet, header included
  localparam int max_packet_width = 48;

  // Async FIFO depth is 2**fifo_lg_depth flits
  localparam int fifo_lg_depth = 3;

  typedef logic [flit_width-1:0]         flit_t;
  typedef logic [coord_width-1:0]        coord_t;
  typedef logic [len_width-1:0]          len_t;
  typedef logic [req_payload_width-1:0]  req_payload_t;
  typedef logic [resp_payload_width-1:0] resp_payload_t;
  typedef logic [max_packet_width-1:0]   packet_t;

endpackage

// ==== cdc_sync.sv ====
// Moves a single level signal from one clock domain into another.
// The level is launched from a source flop, then double synchronized.

module cdc_sync
  (input  logic src_clk_i
  ,input  logic dst_clk_i
  ,input  logic arst_n_i
  ,input  logic data_i
  ,output logic data_o
  );

  logic launch_q;
  logic sync1_q;
  logic sync2_q;

  // Launch flop keeps glitches off the crossing
  always_ff @(posedge src_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      launch_q <= 1'b0;
    end
    else
    begin
      launch_q <= data_i;
    end
  end

  // Two flops in the destination clock
  always_ff @(posedge dst_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
    end
    else
    begin
      sync1_q <= launch_q;
      sync2_q <= sync1_q;
    end
  end

  assign data_o = sync2_q;

endmodule

// ==== async_flit_fifo.sv ====
// Dual-clock flit FIFO with gray-coded pointers.
// Write side and read side each keep their own pointers and see the other
// side's gray pointer through a two-flop synchronizer.

module async_flit_fifo
  (input  logic             w_clk_i
  ,input  logic             r_clk_i
  ,input  logic             arst_n_i
  ,input  logic             w_reset_i
  ,input  logic             r_reset_i
  ,input  logic             w_enq_i
  ,input  mc_wh_pkg::flit_t w_data_i
  ,output logic             w_full_o
  ,input  logic             r_deq_i
  ,output mc_wh_pkg::flit_t r_data_o
  ,output logic             r_valid_o
  );

  // One extra bit tells full from empty
  typedef logic [mc_wh_pkg::fifo_lg_depth:0] ptr_t;

  mc_wh_pkg::flit_t mem [1 << mc_wh_pkg::fifo_lg_depth];

  ptr_t w_bin_q;
  ptr_t w_bin_d;
  ptr_t w_gray_q;
  ptr_t w_gray_d;
  ptr_t r_gray_w1_q;
  ptr_t r_gray_w2_q;
  logic w_live_q;
  logic w_ptr_full;
  logic w_push;

  ptr_t r_bin_q;
  ptr_t r_bin_d;
  ptr_t r_gray_q;
  ptr_t r_gray_d;
  ptr_t w_gray_r1_q;
  ptr_t w_gray_r2_q;
  logic r_pop;

  // Write domain

  // Full when the top two gray bits differ and the rest match
  assign w_ptr_full = (w_gray_q == {~r_gray_w2_q[mc_wh_pkg::fifo_lg_depth -: 2],
                                    r_gray_w2_q[mc_wh_pkg::fifo_lg_depth-2:0]});

  // Reported full until the first clock out of reset
  assign w_full_o = ~w_live_q | w_ptr_full;
  assign w_push   = w_enq_i & ~w_full_o;
  assign w_bin_d  = w_bin_q + ptr_t'(w_push);
  assign w_gray_d = w_bin_d ^ (w_bin_d >> 1);

  always_ff @(posedge w_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      w_live_q    <= 1'b0;
      w_bin_q     <= '0;
      w_gray_q    <= '0;
      r_gray_w1_q <= '0;
      r_gray_w2_q <= '0;
    end
    else if (w_reset_i)
    begin
      w_live_q    <= 1'b0;
      w_bin_q     <= '0;
      w_gray_q    <= '0;
      r_gray_w1_q <= '0;
      r_gray_w2_q <= '0;
    end
    else
    begin
      w_live_q    <= 1'b1;
      w_bin_q     <= w_bin_d;
      w_gray_q    <= w_gray_d;
      r_gray_w1_q <= r_gray_q;
      r_gray_w2_q <= r_gray_w1_q;
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_push)
    begin
      mem[w_bin_q[mc_wh_pkg::fifo_lg_depth-1:0]] <= w_data_i;
    end
  end

  // Read domain

  assign r_valid_o = (r_gray_q != w_gray_r2_q);
  assign r_data_o  = mem[r_bin_q[mc_wh_pkg::fifo_lg_depth-1:0]];
  assign r_pop     = r_deq_i & r_valid_o;
  assign r_bin_d   = r_bin_q + ptr_t'(r_pop);
  assign r_gray_d  = r_bin_d ^ (r_bin_d >> 1);

  always_ff @(posedge r_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      r_bin_q     <= '0;
      r_gray_q    <= '0;
      w_gray_r1_q <= '0;
      w_gray_r2_q <= '0;
    end
    else if (r_reset_i)
    begin
      r_bin_q     <= '0;
      r_gray_q    <= '0;
      w_gray_r1_q <= '0;
      w_gray_r2_q <= '0;
    end
    else
    begin
      r_bin_q     <= r_bin_d;
      r_gray_q    <= r_gray_d;
      w_gray_r1_q <= w_gray_q;
      w_gray_r2_q <= w_gray_r1_q;
    end
  end

endmodule

// ==== flit_serializer.sv ====
// Takes one packet and hands it out as num_flits flits.
// Lowest flit goes first, so the header leads the packet.

module flit_serializer
 #(parameter int num_flits = 3)
  (input  logic               clk_i
  ,input  logic               arst_n_i
  ,input  logic               reset_i
  ,input  logic               valid_i
  ,input  mc_wh_pkg::packet_t data_i
  ,output logic               ready_o
  ,output logic               valid_o
  ,output mc_wh_pkg::flit_t   data_o
  ,input  logic               ready_i
  );

  typedef logic [$clog2(num_flits)-1:0] count_t;
  typedef enum logic [1:0] {st_init, st_idle, st_send} state_e;

  state_e             state_q;
  count_t             count_q;
  mc_wh_pkg::packet_t shift_q;

  assign ready_o = (state_q == st_idle);
  assign valid_o = (state_q == st_send);
  assign data_o  = shift_q[mc_wh_pkg::flit_width-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= st_init;
      count_q <= '0;
    end
    else if (reset_i)
    begin
      state_q <= st_init;
      count_q <= '0;
    end
    else
    begin
      case (state_q)
        st_init: state_q <= st_idle;
        st_idle:
        begin
          if (valid_i)
          begin
            state_q <= st_send;
            count_q <= '0;
          end
        end
        default:
        begin
          if (ready_i)
          begin
            if (count_q == count_t'(num_flits - 1))
              state_q <= st_idle;
            else
              count_q <= count_q + count_t'(1);
          end
        end
      endcase
    end
  end

  // Next flit drops into the low slot on each transfer
  always_ff @(posedge clk_i)
  begin
    if (valid_i && ready_o)
      shift_q <= data_i;
    else if (valid_o && ready_i)
      shift_q <= shift_q >> mc_wh_pkg::flit_width;
  end

endmodule

// ==== flit_deserializer.sv ====
// Gathers num_flits flits into one packet, first flit in the low slot.
// An assembly buffer keeps filling while the finished packet waits.

module flit_deserializer
 #(parameter int num_flits = 3)
  (input  logic               clk_i
  ,input  logic               arst_n_i
  ,input  logic               reset_i
  ,input  logic               valid_i
  ,input  mc_wh_pkg::flit_t   data_i
  ,output logic               ready_o
  ,output logic               valid_o
  ,output mc_wh_pkg::packet_t data_o
  ,input  logic               ready_i
  );

  typedef logic [$clog2(num_flits)-1:0] count_t;

  mc_wh_pkg::packet_t asm_q;
  mc_wh_pkg::packet_t asm_d;
  mc_wh_pkg::packet_t out_q;
  count_t             count_q;
  logic               asm_full_q;
  logic               out_valid_q;
  logic               push;
  logic               last;
  logic               out_free;
  logic               load_new;
  logic               load_held;

  assign ready_o   = ~asm_full_q;
  assign valid_o   = out_valid_q;
  assign data_o    = out_q;
  assign push      = valid_i & ready_o;
  assign last      = (count_q == count_t'(num_flits - 1));
  assign out_free  = ~out_valid_q | ready_i;
  assign load_new  = push & last & out_free;
  assign load_held = asm_full_q & out_free;

  // Assembly buffer with the incoming flit in its slot
  always_comb
  begin
    asm_d = asm_q;
    asm_d[count_q*mc_wh_pkg::flit_width +: mc_wh_pkg::flit_width] = data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_q     <= '0;
      asm_full_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else if (reset_i)
    begin
      count_q     <= '0;
      asm_full_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      if (push)
        count_q <= last ? '0 : count_q + count_t'(1);
      if (push && last && !out_free)
        asm_full_q <= 1'b1;
      else if (load_held)
        asm_full_q <= 1'b0;
      if (load_new || load_held)
        out_valid_q <= 1'b1;
      else if (ready_i)
        out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      asm_q <= asm_d;
    if (load_new)
      out_q <= asm_d;
    else if (load_held)
      out_q <= asm_q;
  end

endmodule

// ==== mc_wh_net_adapter.sv ====
// One bridge net between the manycore clock and the network clock.
// Outgoing payloads get a wormhole header and leave as flits; incoming
// flits are gathered and the header is stripped again.

module mc_wh_net_adapter
 #(parameter int num_flits     = 3
  ,parameter int payload_width = 38)
  (input  logic                     manycore_clk_i
  ,input  logic                     clk_i
  ,input  logic                     arst_n_i
  ,input  logic                     mc_reset_i
  ,input  mc_wh_pkg::coord_t        dest_x_i
  ,input  mc_wh_pkg::coord_t        dest_y_i
  ,input  logic                     mc_v_i
  ,input  logic [payload_width-1:0] mc_data_i
  ,output logic                     mc_ready_o
  ,output logic                     mc_v_o
  ,output logic [payload_width-1:0] mc_data_o
  ,input  logic                     mc_ready_i
  ,input  logic                     link_v_i
  ,input  mc_wh_pkg::flit_t         link_data_i
  ,output logic                     link_ready_o
  ,output logic                     link_v_o
  ,output mc_wh_pkg::flit_t         link_data_o
  ,input  logic                     link_ready_i
  );

  mc_wh_pkg::packet_t out_pkt;
  mc_wh_pkg::packet_t in_pkt;
  mc_wh_pkg::flit_t   ser_data;
  mc_wh_pkg::flit_t   in_flit;
  logic               ser_v;
  logic               out_full;
  logic               in_full;
  logic               in_v;
  logic               des_ready;

  // Header is {len, y, x} with the payload right above it
  always_comb
  begin
    out_pkt = '0;
    out_pkt[mc_wh_pkg::header_width-1:0] =
      {mc_wh_pkg::len_t'(num_flits - 1), dest_y_i, dest_x_i};
    out_pkt[mc_wh_pkg::header_width +: payload_width] = mc_data_i;
  end

  assign mc_data_o    = in_pkt[mc_wh_pkg::header_width +: payload_width];
  assign link_ready_o = ~in_full;

  flit_serializer
 #(.num_flits(num_flits))
  ser
  (.clk_i(manycore_clk_i)
  ,.arst_n_i(arst_n_i)
  ,.reset_i(mc_reset_i)
  ,.valid_i(mc_v_i)
  ,.data_i(out_pkt)
  ,.ready_o(mc_ready_o)
  ,.valid_o(ser_v)
  ,.data_o(ser_data)
  ,.ready_i(~out_full));

  // Manycore to network
  async_flit_fifo
  mc_2_wh_fifo
  (.w_clk_i(manycore_clk_i)
  ,.r_clk_i(clk_i)
  ,.arst_n_i(arst_n_i)
  ,.w_reset_i(mc_reset_i)
  ,.r_reset_i(1'b0)
  ,.w_enq_i(ser_v & ~out_full)
  ,.w_data_i(ser_data)
  ,.w_full_o(out_full)
  ,.r_deq_i(link_v_o & link_ready_i)
  ,.r_data_o(link_data_o)
  ,.r_valid_o(link_v_o));

  // Network to manycore
  async_flit_fifo
  wh_2_mc_fifo
  (.w_clk_i(clk_i)
  ,.r_clk_i(manycore_clk_i)
  ,.arst_n_i(arst_n_i)
  ,.w_reset_i(1'b0)
  ,.r_reset_i(mc_reset_i)
  ,.w_enq_i(link_v_i & link_ready_o)
  ,.w_data_i(link_data_i)
  ,.w_full_o(in_full)
  ,.r_deq_i(in_v & des_ready)
  ,.r_data_o(in_flit)
  ,.r_valid_o(in_v));

  flit_deserializer
 #(.num_flits(num_flits))
  des
  (.clk_i(manycore_clk_i)
  ,.arst_n_i(arst_n_i)
  ,.reset_i(mc_reset_i)
  ,.valid_i(in_v)
  ,.data_i(in_flit)
  ,.ready_o(des_ready)
  ,.valid_o(mc_v_o)
  ,.data_o(in_pkt)
  ,.ready_i(mc_ready_i));

endmodule

// ==== mc_link_async_to_wormhole.sv ====
// Top of the bridge between the manycore link and the wormhole network.
// Requests and responses each use their own net; the manycore reset and
// enable levels are carried over from the network clock.

module mc_link_async_to_wormhole
  (input  logic                     manycore_clk_i
  ,input  logic                     clk_i
  ,input  logic                     arst_n_i
  ,input  logic                     manycore_reset_i
  ,input  logic                     manycore_en_i
  ,output logic                     manycore_reset_o
  ,output logic                     manycore_en_o
  ,input  mc_wh_pkg::coord_t        dest_x_i
  ,input  mc_wh_pkg::coord_t        dest_y_i
  ,input  logic                     fwd_v_i
  ,input  mc_wh_pkg::req_payload_t  fwd_data_i
  ,output logic                     fwd_ready_o
  ,output logic                     fwd_v_o
  ,output mc_wh_pkg::req_payload_t  fwd_data_o
  ,input  logic                     fwd_ready_i
  ,input  logic                     rev_v_i
  ,input  mc_wh_pkg::resp_payload_t rev_data_i
  ,output logic                     rev_ready_o
  ,output logic                     rev_v_o
  ,output mc_wh_pkg::resp_payload_t rev_data_o
  ,input  logic                     rev_ready_i
  ,output logic                     req_link_v_o
  ,output mc_wh_pkg::flit_t         req_link_data_o
  ,input  logic                     req_link_ready_i
  ,input  logic                     req_link_v_i
  ,input  mc_wh_pkg::flit_t         req_link_data_i
  ,output logic                     req_link_ready_o
  ,output logic                     resp_link_v_o
  ,output mc_wh_pkg::flit_t         resp_link_data_o
  ,input  logic                     resp_link_ready_i
  ,input  logic                     resp_link_v_i
  ,input  mc_wh_pkg::flit_t         resp_link_data_i
  ,output logic                     resp_link_ready_o
  );

  cdc_sync
  mc_reset_sync
  (.src_clk_i(clk_i)
  ,.dst_clk_i(manycore_clk_i)
  ,.arst_n_i(arst_n_i)
  ,.data_i(manycore_reset_i)
  ,.data_o(manycore_reset_o));

  cdc_sync
  mc_en_sync
  (.src_clk_i(clk_i)
  ,.dst_clk_i(manycore_clk_i)
  ,.arst_n_i(arst_n_i)
  ,.data_i(manycore_en_i)
  ,.data_o(manycore_en_o));

  // Request net
  mc_wh_net_adapter
 #(.num_flits(mc_wh_pkg::req_flits)
  ,.payload_width(mc_wh_pkg::req_payload_width))
  req_net
  (.manycore_clk_i(manycore_clk_i), .clk_i(clk_i), .arst_n_i(arst_n_i)
  ,.mc_reset_i(manycore_reset_o), .dest_x_i(dest_x_i), .dest_y_i(dest_y_i)
  ,.mc_v_i(fwd_v_i), .mc_data_i(fwd_data_i), .mc_ready_o(fwd_ready_o)
  ,.mc_v_o(fwd_v_o), .mc_data_o(fwd_data_o), .mc_ready_i(fwd_ready_i)
  ,.link_v_i(req_link_v_i), .link_data_i(req_link_data_i)
  ,.link_ready_o(req_link_ready_o)
  ,.link_v_o(req_link_v_o), .link_data_o(req_link_data_o)
  ,.link_ready_i(req_link_ready_i));

  // Response net
  mc_wh_net_adapter
 #(.num_flits(mc_wh_pkg::resp_flits)
  ,.payload_width(mc_wh_pkg::resp_payload_width))
  resp_net
  (.manycore_clk_i(manycore_clk_i), .clk_i(clk_i), .arst_n_i(arst_n_i)
  ,.mc_reset_i(manycore_reset_o), .dest_x_i(dest_x_i), .dest_y_i(dest_y_i)
  ,.mc_v_i(rev_v_i), .mc_data_i(rev_data_i), .mc_ready_o(rev_ready_o)
  ,.mc_v_o(rev_v_o), .mc_data_o(rev_data_o), .mc_ready_i(rev_ready_i)
  ,.link_v_i(resp_link_v_i), .link_data_i(resp_link_data_i)
  ,.link_ready_o(resp_link_ready_o)
  ,.link_v_o(resp_link_v_o), .link_data_o(resp_link_data_o)
  ,.link_ready_i(resp_link_ready_i));

endmodule

// ==== mc_link_async_to_wormhole_asserts.sv ====
// Protocol assertions for the bridge top, attached with bind.
// Stalled valid outputs must hold, and nothing is valid in reset.

module mc_link_async_to_wormhole_asserts
  (input logic                     clk_i
  ,input logic                     manycore_clk_i
  ,input logic                     arst_n_i
  ,input logic                     manycore_reset_o
  ,input logic                     req_link_v_o
  ,input logic                     req_link_ready_i
  ,input mc_wh_pkg::flit_t         req_link_data_o
  ,input logic                     resp_link_v_o
  ,input logic                     resp_link_ready_i
  ,input mc_wh_pkg::flit_t         resp_link_data_o
  ,input logic                     fwd_v_o
  ,input logic                     fwd_ready_i
  ,input mc_wh_pkg::req_payload_t  fwd_data_o
  ,input logic                     rev_v_o
  ,input logic                     rev_ready_i
  ,input mc_wh_pkg::resp_payload_t rev_data_o
  );

  req_link_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i || manycore_reset_o)
    req_link_v_o && !req_link_ready_i |=> req_link_v_o && $stable(req_link_data_o))
    else $error("req link flit dropped or changed while stalled");

  resp_link_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i || manycore_reset_o)
    resp_link_v_o && !resp_link_ready_i |=> resp_link_v_o && $stable(resp_link_data_o))
    else $error("resp link flit dropped or changed while stalled");

  fwd_hold: assert property (@(posedge manycore_clk_i) disable iff (!arst_n_i || manycore_reset_o)
    fwd_v_o && !fwd_ready_i |=> fwd_v_o && $stable(fwd_data_o))
    else $error("fwd payload dropped or changed while stalled");

  rev_hold: assert property (@(posedge manycore_clk_i) disable iff (!arst_n_i || manycore_reset_o)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_data_o))
    else $error("rev payload dropped or changed while stalled");

  // Nothing valid while the asynchronous reset is held
  net_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !req_link_v_o && !resp_link_v_o)
    else $error("link valid high during reset");

  mc_quiet: assert property (@(posedge manycore_clk_i) !arst_n_i |-> !fwd_v_o && !rev_v_o)
    else $error("manycore valid high during reset");

endmodule

bind mc_link_async_to_wormhole mc_link_async_to_wormhole_asserts asserts_inst
  (.clk_i(clk_i), .manycore_clk_i(manycore_clk_i), .arst_n_i(arst_n_i)
  ,.manycore_reset_o(manycore_reset_o)
  ,.req_link_v_o(req_link_v_o), .req_link_ready_i(req_link_ready_i)
  ,.req_link_data_o(req_link_data_o)
  ,.resp_link_v_o(resp_link_v_o), .resp_link_ready_i(resp_link_ready_i)
  ,.resp_link_data_o(resp_link_data_o)
  ,.fwd_v_o(fwd_v_o), .fwd_ready_i(fwd_ready_i), .fwd_data_o(fwd_data_o)
  ,.rev_v_o(rev_v_o), .rev_ready_i(rev_ready_i), .rev_data_o(rev_data_o));

// ==== tb_mc_link_async_to_wormhole.sv ====
// Testbench for the manycore to wormhole bridge.
// Replays mc_link_vectors.txt on both nets under random back-pressure and
// checks flits, payloads and the synchronized reset and enable levels.

module tb_mc_link_async_to_wormhole;

  logic                     manycore_clk_i, clk_i, arst_n_i;
  logic                     manycore_reset_i, manycore_en_i;
  logic                     manycore_reset_o, manycore_en_o;
  mc_wh_pkg::coord_t        dest_x_i, dest_y_i;
  logic                     fwd_v_i, fwd_ready_o, fwd_v_o, fwd_ready_i;
  mc_wh_pkg::req_payload_t  fwd_data_i, fwd_data_o;
  logic                     rev_v_i, rev_ready_o, rev_v_o, rev_ready_i;
  mc_wh_pkg::resp_payload_t rev_data_i, rev_data_o;
  logic                     req_link_v_o, req_link_ready_i, req_link_v_i, req_link_ready_o;
  mc_wh_pkg::flit_t         req_link_data_o, req_link_data_i;
  logic                     resp_link_v_o, resp_link_ready_i, resp_link_v_i, resp_link_ready_o;
  mc_wh_pkg::flit_t         resp_link_data_o, resp_link_data_i;

  // Four words per vector: kind, data, destination, expected
  logic [63:0] vec_mem [0:255];

  // Expected flits and payloads, oldest first
  mc_wh_pkg::flit_t         req_flit_q[$];
  mc_wh_pkg::flit_t         resp_flit_q[$];
  mc_wh_pkg::req_payload_t  fwd_exp_q[$];
  mc_wh_pkg::resp_payload_t rev_exp_q[$];

  mc_link_async_to_wormhole mc_link_async_to_wormhole_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial
  begin
    manycore_clk_i = 1'b0;
    forever #7 manycore_clk_i = ~manycore_clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Network side stalls, ready about three cycles in four
  initial
  begin : net_stalls
    logic [31:0] seed;
    seed = 32'd64;
    forever
    begin
      @(posedge clk_i);
      #1;
      seed = lcg_next(seed);
      req_link_ready_i  = seed[16] | seed[17];
      resp_link_ready_i = seed[18] | seed[19];
    end
  end

  // Manycore side stalls
  initial
  begin : mc_stalls
    logic [31:0] seed;
    seed = 32'd64;
    forever
    begin
      @(posedge manycore_clk_i);
      #1;
      seed = lcg_next(seed);
      fwd_ready_i = seed[20] | seed[21];
      rev_ready_i = seed[22] | seed[23];
    end
  end

  task automatic fail_and_stop();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic guard_timeout(input int count, input string what);
    if (count >= 200)
    begin
      $display("Timeout after %0d cycles while waiting for %s", count, what);
      fail_and_stop();
    end
  endtask

  task automatic report_unexpected(input string name);
    $display("Transfer on %s at %0t with nothing left to expect", name, $time);
    fail_and_stop();
  endtask

  task automatic check_flit(input string name, input mc_wh_pkg::flit_t got,
                            input mc_wh_pkg::flit_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_req(input string name, input mc_wh_pkg::req_payload_t got,
                           input mc_wh_pkg::req_payload_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_resp(input string name, input mc_wh_pkg::resp_payload_t got,
                            input mc_wh_pkg::resp_payload_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  // Every accepted flit must be the oldest one still expected
  always @(posedge clk_i)
  begin
    if (req_link_v_o && req_link_ready_i)
    begin
      if (req_flit_q.size() == 0)
        report_unexpected("req_link_data_o");
      else
        check_flit("req_link_data_o", req_link_data_o, req_flit_q.pop_front());
    end
    if (resp_link_v_o && resp_link_ready_i)
    begin
      if (resp_flit_q.size() == 0)
        report_unexpected("resp_link_data_o");
      else
        check_flit("resp_link_data_o", resp_link_data_o, resp_flit_q.pop_front());
    end
  end

  // Same for payloads handed back to the manycore
  always @(posedge manycore_clk_i)
  begin
    if (fwd_v_o && fwd_ready_i)
    begin
      if (fwd_exp_q.size() == 0)
        report_unexpected("fwd_data_o");
      else
        check_req("fwd_data_o", fwd_data_o, fwd_exp_q.pop_front());
    end
    if (rev_v_o && rev_ready_i)
    begin
      if (rev_exp_q.size() == 0)
        report_unexpected("rev_data_o");
      else
        check_resp("rev_data_o", rev_data_o, rev_exp_q.pop_front());
    end
  end

  function automatic int outstanding();
    return req_flit_q.size() + resp_flit_q.size() + fwd_exp_q.size() + rev_exp_q.size();
  endfunction

  // Waits until every expected flit and payload has been seen
  task automatic wait_drained();
    int count;
    count = 0;
    while (outstanding() != 0)
    begin
      @(posedge manycore_clk_i);
      count++;
      guard_timeout(count, "outstanding flits and payloads");
    end
  endtask

  // Valids, readies and both levels are low while reset is held
  task automatic check_reset_outputs();
    check_bit("fwd_v_o", fwd_v_o, 1'b0);
    check_bit("fwd_ready_o", fwd_ready_o, 1'b0);
    check_bit("rev_v_o", rev_v_o, 1'b0);
    check_bit("rev_ready_o", rev_ready_o, 1'b0);
    check_bit("req_link_v_o", req_link_v_o, 1'b0);
    check_bit("req_link_ready_o", req_link_ready_o, 1'b0);
    check_bit("resp_link_v_o", resp_link_v_o, 1'b0);
    check_bit("resp_link_ready_o", resp_link_ready_o, 1'b0);
    check_bit("manycore_reset_o", manycore_reset_o, 1'b0);
    check_bit("manycore_en_o", manycore_en_o, 1'b0);
  endtask

  // Offers one payload on fwd or rev until the bridge takes it
  task automatic send_payload(input logic is_req, input logic [63:0] data,
                              input logic [7:0] dest);
    int   count;
    logic taken;
    @(posedge manycore_clk_i);
    #1;
    dest_x_i   = dest[3:0];
    dest_y_i   = dest[7:4];
    fwd_v_i    = is_req;
    rev_v_i    = !is_req;
    fwd_data_i = data[mc_wh_pkg::req_payload_width-1:0];
    rev_data_i = data[mc_wh_pkg::resp_payload_width-1:0];
    taken = 1'b0;
    count = 0;
    while (!taken)
    begin
      @(posedge manycore_clk_i);
      taken = is_req ? fwd_ready_o : rev_ready_o;
      count++;
      if (!taken)
        guard_timeout(count, is_req ? "fwd_ready_o" : "rev_ready_o");
    end
    #1;
    fwd_v_i = 1'b0;
    rev_v_i = 1'b0;
  endtask

  // Header flit first, then the payload flits
  task automatic expect_flits(input logic is_req, input logic [63:0] exp);
    int nf;
    int k;
    nf = is_req ? mc_wh_pkg::req_flits : mc_wh_pkg::resp_flits;
    for (k = 0; k < nf; k++)
    begin
      if (is_req)
        req_flit_q.push_back(exp[k*mc_wh_pkg::flit_width +: mc_wh_pkg::flit_width]);
      else
        resp_flit_q.push_back(exp[k*mc_wh_pkg::flit_width +: mc_wh_pkg::flit_width]);
    end
  endtask

  task automatic drive_flits(input logic is_req, input logic [63:0] pkt);
    int   nf;
    int   k;
    int   count;
    logic taken;
    nf = is_req ? mc_wh_pkg::req_flits : mc_wh_pkg::resp_flits;
    @(posedge clk_i);
    for (k = 0; k < nf; k++)
    begin
      #1;
      req_link_v_i     = is_req;
      resp_link_v_i    = !is_req;
      req_link_data_i  = pkt[k*mc_wh_pkg::flit_width +: mc_wh_pkg::flit_width];
      resp_link_data_i = pkt[k*mc_wh_pkg::flit_width +: mc_wh_pkg::flit_width];
      taken = 1'b0;
      count = 0;
      while (!taken)
      begin
        @(posedge clk_i);
        taken = is_req ? req_link_ready_o : resp_link_ready_o;
        count++;
        if (!taken)
          guard_timeout(count, is_req ? "req_link_ready_o" : "resp_link_ready_o");
      end
    end
    #1;
    req_link_v_i  = 1'b0;
    resp_link_v_i = 1'b0;
  endtask

  // Levels must show up within 6 manycore cycles
  task automatic apply_levels(input logic [1:0] levels, input logic [1:0] exp);
    int count;
    @(posedge clk_i);
    #1;
    manycore_reset_i = levels[1];
    manycore_en_i    = levels[0];
    count = 0;
    while ({manycore_reset_o, manycore_en_o} !== exp && count < 6)
    begin
      @(posedge manycore_clk_i);
      count++;
    end
    check_bit("manycore_reset_o", manycore_reset_o, exp[1]);
    check_bit("manycore_en_o", manycore_en_o, exp[0]);
  endtask

  initial
  begin : main
    int idx;
    arst_n_i          = 1'b0;
    manycore_reset_i  = 1'b0;
    manycore_en_i     = 1'b0;
    dest_x_i          = '0;
    dest_y_i          = '0;
    fwd_v_i           = 1'b0;
    fwd_data_i        = '0;
    fwd_ready_i       = 1'b0;
    rev_v_i           = 1'b0;
    rev_data_i        = '0;
    rev_ready_i       = 1'b0;
    req_link_v_i      = 1'b0;
    req_link_data_i   = '0;
    req_link_ready_i  = 1'b0;
    resp_link_v_i     = 1'b0;
    resp_link_data_i  = '0;
    resp_link_ready_i = 1'b0;
    $readmemh("mc_link_vectors.txt", vec_mem);
    repeat (10) @(posedge clk_i);
    #1;
    check_reset_outputs();
    arst_n_i = 1'b1;
    idx = 0;
    // Packets are not awaited one by one, so several stay in flight
    while (idx <= 252 && vec_mem[idx] != 64'd0)
    begin
      case (vec_mem[idx])
        64'd1:
        begin
          expect_flits(1'b1, vec_mem[idx+3]);
          send_payload(1'b1, vec_mem[idx+1], vec_mem[idx+2][7:0]);
        end
        64'd2:
        begin
          expect_flits(1'b0, vec_mem[idx+3]);
          send_payload(1'b0, vec_mem[idx+1], vec_mem[idx+2][7:0]);
        end
        64'd3:
        begin
          fwd_exp_q.push_back(vec_mem[idx+3][mc_wh_pkg::req_payload_width-1:0]);
          drive_flits(1'b1, vec_mem[idx+1]);
        end
        64'd4:
        begin
          rev_exp_q.push_back(vec_mem[idx+3][mc_wh_pkg::resp_payload_width-1:0]);
          drive_flits(1'b0, vec_mem[idx+1]);
        end
        64'd5:
        begin
          wait_drained();
          apply_levels(vec_mem[idx+1][1:0], vec_mem[idx+3][1:0]);
        end
        default:
        begin
          $display("Unknown vector kind %0h at word %0d", vec_mem[idx], idx);
          fail_and_stop();
        end
      endcase
      idx += 4;
    end
    wait_drained();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== mc_link_vectors.txt ====
// Columns: kind, data, destination {y,x}, expected; all hex
// Kind 1 req out, 2 resp out, 3 req in, 4 resp in, 5 reset and enable levels, 0 ends
5 2 0 2
5 3 0 3
5 1 0 1
1 0000000001 53 000000000653
3 48D159E26A21 00 123456789A
2 2AAAAA 47 AAAAA947
4 2AF379FF 00 0ABCDE
1 3FFFFFFFFF CA FFFFFFFFFECA
1 123456789A 21 48D159E26A21
4 AAAAA947 00 2AAAAA
3 123456789ABC 00 048D159E26
2 3FFFFF 00 FFFFFD00
2 0ABCDE FF 2AF379FF
3 000000000653 00 0000000001
4 12345678 00 048D15
3 FFFFFFFFFECA 00 3FFFFFFFFF
4 FFFFFD00 00 3FFFFF
5 0 0 0
0 0 0 0

// ==== list.f ====
mc_wh_pkg.sv
cdc_sync.sv
async_flit_fifo.sv
flit_serializer.sv
flit_deserializer.sv
mc_wh_net_adapter.sv
mc_link_async_to_wormhole.sv
mc_link_async_to_wormhole_asserts.sv
tb_mc_link_async_to_wormhole.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_mc_link_async_to_wormhole -o tb_sim \
  && ./obj_dir/tb_sim | grep -F -x '*** PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
